// ==== vdp_params.svh ====
`ifndef VDP_PARAMS_SVH
`define VDP_PARAMS_SVH

// ------------------------------
// VRAM geometry
// ------------------------------
// Byte address into 128 KB of VRAM
`define VDP_VRAM_AW 17

// ------------------------------
// Control register file
// ------------------------------
`define VDP_REG_COUNT 48

// ------------------------------
// Store model timing
// ------------------------------
// Read accept to rdata_en
`define VDP_VRAM_LATENCY 3
// Busy after reset, stands in for SDRAM init
`define VDP_VRAM_INIT_CYCLES 64

`endif

// ==== vdp_bus_pkg.sv ====
`include "vdp_params.svh"

package vdp_bus_pkg;

	// Host port numbers, as on the MSX I/O map
	typedef enum logic [1:0] {PORT_DATA, PORT_CTRL, PORT_PALETTE, PORT_INDIRECT} vdp_port_e;

	// One host access
	typedef struct packed {
		logic			req;		// One cycle pulse
		logic			wr;			// 1 = write
		vdp_port_e		port;
		logic	[7:0]	wdata;
	} vdp_host_req_t;

	// ------------------------------
	// Second control byte
	// ------------------------------
	typedef struct packed {
		logic			flag;		// 1 = register write
		logic			spare;
		logic	[5:0]	reg_num;
	} vdp_ctrl_reg_t;

	typedef struct packed {
		logic			flag;		// 0 = address setup
		logic			wr_mode;	// 1 = write mode, no read-ahead
		logic	[5:0]	addr_hi;	// VRAM address 13..8
	} vdp_ctrl_addr_t;

	// Same byte, decoded by its flag bit
	typedef union packed {
		vdp_ctrl_reg_t	reg_view;
		vdp_ctrl_addr_t	addr_view;
	} vdp_ctrl_byte_u;

	// R#0 .. R#47 for the display side
	typedef logic [`VDP_REG_COUNT-1:0][7:0] vdp_regs_t;

endpackage

// ==== vdp_vram_pkg.sv ====
`include "vdp_params.svh"

package vdp_vram_pkg;

	// ------------------------------
	// Decoder to sequencer
	// ------------------------------
	typedef struct packed {
		logic							valid;		// Level, held until accept
		logic							write;
		logic	[`VDP_VRAM_AW-1:0]		address;	// Byte address
		logic	[7:0]					data;		// Write byte only
	} vram_req_t;

	// ------------------------------
	// Store to sequencer
	// ------------------------------
	typedef struct packed {
		logic			rdata_en;	// One cycle per read
		logic	[15:0]	rdata;		// Whole word, both lanes
	} vram_rsp_t;

endpackage

// ==== vdp_port_decoder.sv ====
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_port_decoder (
	input							clk,
	input							w_n_reset,
	input	vdp_bus_pkg::vdp_host_req_t	host,
	output	logic					ack,
	output	logic	[7:0]			rdata,
	output	vdp_vram_pkg::vram_req_t	vram_req,
	input							accept,
	input							byte_valid,
	input			[7:0]			read_byte,
	output	vdp_bus_pkg::vdp_regs_t	regs
);

	vdp_bus_pkg::vdp_ctrl_byte_u	w_ctrl;
	vdp_bus_pkg::vdp_regs_t			ff_regs;
	vdp_vram_pkg::vram_req_t		ff_vram;
	logic					ff_latch_full;		// First control byte held
	logic	[7:0]			ff_first_byte;
	logic	[13:0]			ff_addr_lo;			// Bits 16..14 live in R#14
	logic					ff_ack;
	logic	[7:0]			ff_rdata;
	logic					ff_wr_pend;
	logic	[7:0]			ff_wr_data;
	logic					ff_rd_pend;
	logic	[7:0]			ff_rbuf;			// Read-ahead byte
	logic					ff_rbuf_valid;
	logic					ff_ra_req;			// Read-ahead wanted at current address
	logic					ff_ra_busy;			// Read-ahead in flight
	logic					ff_ra_stale;		// In-flight byte to be dropped
	logic					w_host_data, w_host_ctrl_wr, w_second_byte;
	logic					w_new_wr, w_wr_waiting, w_rd_waiting, w_invalidate;
	logic	[7:0]			w_wr_byte;
	logic					w_slot_free, w_wr_ack, w_rd_ack, w_ra_load;
	logic	[14:0]			w_lo_next;
	logic	[`VDP_VRAM_AW-1:0]	w_vram_addr;

	// ------------------------------
	// Host decode
	// ------------------------------
	assign w_ctrl			= host.wdata;
	assign w_host_data		= host.req & (host.port == vdp_bus_pkg::PORT_DATA);
	assign w_host_ctrl_wr	= host.req & host.wr & (host.port == vdp_bus_pkg::PORT_CTRL);
	assign w_second_byte	= w_host_ctrl_wr & ff_latch_full;
	assign w_new_wr			= w_host_data & host.wr;
	assign w_wr_waiting		= w_new_wr | ff_wr_pend;
	assign w_wr_byte		= w_new_wr ? host.wdata : ff_wr_data;
	assign w_rd_waiting		= (w_host_data & ~host.wr) | ff_rd_pend;
	assign w_invalidate		= w_new_wr | w_second_byte;		// Buffer no longer matches

	// Request register frees up in the accept cycle
	assign w_slot_free		= ~ff_vram.valid | accept;
	assign w_wr_ack			= accept & ff_vram.write;
	assign w_rd_ack			= w_rd_waiting & ff_rbuf_valid;
	// One read-ahead outstanding at a time, writes go first
	assign w_ra_load		= ff_ra_req & ~ff_ra_busy & w_slot_free & ~w_wr_waiting & ~w_invalidate;

	// Carry out of bit 13 bumps R#14
	assign w_lo_next		= {1'b0, ff_addr_lo} + 15'd1;
	assign w_vram_addr		= {ff_regs[14][`VDP_VRAM_AW-15:0], ff_addr_lo};

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_latch_full	<= 1'b0;
			ff_addr_lo		<= '0;
			ff_regs			<= '0;
			ff_ack			<= 1'b0;
			ff_vram			<= '0;
			ff_wr_pend		<= 1'b0;
			ff_rd_pend		<= 1'b0;
			ff_rbuf_valid	<= 1'b0;
			ff_ra_req		<= 1'b0;
			ff_ra_busy		<= 1'b0;
			ff_ra_stale		<= 1'b0;
		end
		else begin
			ff_ack <= (host.req & ~w_host_data) | w_rd_ack;	// Ports 1..3 and buffered reads

			// Control latch, any data access resyncs it
			if (w_host_data) begin
				ff_latch_full <= 1'b0;
			end
			else if (w_host_ctrl_wr) begin
				ff_latch_full <= ~ff_latch_full;
			end
			if (w_second_byte) begin
				if (w_ctrl.reg_view.flag) begin
					if (w_ctrl.reg_view.reg_num < `VDP_REG_COUNT) begin
						ff_regs[w_ctrl.reg_view.reg_num] <= ff_first_byte;
					end
				end
				else begin
					ff_addr_lo <= {w_ctrl.addr_view.addr_hi, ff_first_byte};
				end
			end

			// Auto-increment on each data ack
			if (w_wr_ack | w_rd_ack) begin
				ff_addr_lo <= w_lo_next[13:0];
				if (w_lo_next[14]) begin
					ff_regs[14][2:0] <= ff_regs[14][2:0] + 3'd1;
				end
			end

			// VRAM request, held until accepted
			if (w_wr_waiting & w_slot_free) begin
				ff_vram <= '{valid: 1'b1, write: 1'b1, address: w_vram_addr, data: w_wr_byte};
			end
			else if (w_ra_load) begin
				ff_vram <= '{valid: 1'b1, write: 1'b0, address: w_vram_addr, data: 8'h00};
			end
			else if (accept) begin
				ff_vram.valid <= 1'b0;
			end
			ff_wr_pend <= w_wr_waiting & ~w_slot_free;
			ff_rd_pend <= w_rd_waiting & ~ff_rbuf_valid;

			// Read-ahead buffer
			if (byte_valid) begin
				ff_ra_busy		<= 1'b0;
				ff_ra_stale		<= 1'b0;
				ff_rbuf_valid	<= ~ff_ra_stale;
			end
			if (w_ra_load) begin
				ff_ra_busy <= 1'b1;
			end
			if (w_rd_ack) begin
				ff_rbuf_valid <= 1'b0;
			end
			if (w_invalidate) begin
				ff_rbuf_valid	<= 1'b0;
				ff_ra_stale		<= ff_ra_busy & ~byte_valid;
				// Read-mode setup queues the first read-ahead
				ff_ra_req		<= w_second_byte & ~w_ctrl.addr_view.flag &
					~w_ctrl.addr_view.wr_mode;
			end
			else if (w_rd_ack) begin
				ff_ra_req <= 1'b1;			// Next byte
			end
			else if (w_ra_load) begin
				ff_ra_req <= 1'b0;
			end
			else if (w_rd_waiting & ~ff_rbuf_valid & ~ff_ra_busy) begin
				ff_ra_req <= 1'b1;			// Buffer was dropped, fetch on demand
			end
		end
	end

	// Payload, no reset
	always_ff @(posedge clk) begin
		if (w_wr_waiting) begin
			ff_wr_data <= w_wr_byte;
		end
		if (w_host_ctrl_wr & ~ff_latch_full) begin
			ff_first_byte <= host.wdata;
		end
		if (byte_valid) begin
			ff_rbuf <= read_byte;
		end
		if (w_rd_ack) begin
			ff_rdata <= ff_rbuf;
		end
	end

	assign ack		= ff_ack | w_wr_ack;		// Write ack rides on accept
	assign rdata	= ff_rdata;
	assign vram_req	= ff_vram;
	assign regs		= ff_regs;

endmodule

// ==== vdp_vram_sequencer.sv ====
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_vram_sequencer (
	input								clk,
	input								w_n_reset,
	input	vdp_vram_pkg::vram_req_t	vram_req,
	output	logic						accept,
	output	logic						rd_n,
	output	logic						wr_n,
	output	logic	[`VDP_VRAM_AW-1:0]	address,
	output	logic	[7:0]				wdata,
	input								busy,
	input	vdp_vram_pkg::vram_rsp_t	rsp,
	output	logic						byte_valid,
	output	logic	[7:0]				read_byte
);

	vdp_vram_pkg::vram_req_t		ff_slot;		// One-entry request slot
	logic	[`VDP_VRAM_LATENCY-1:0]	ff_lane_q;		// Address bit 0 per read in flight
	logic							ff_byte_valid;
	logic	[7:0]					ff_read_byte;
	logic							w_issue;
	logic							w_lane_hi;

	// ------------------------------
	// Slot and strobes
	// ------------------------------
	assign accept	= vram_req.valid & ~ff_slot.valid;
	assign w_issue	= ff_slot.valid & ~busy;

	// Strobe lasts the one issue cycle, slot empties at the edge
	assign rd_n		= ~(w_issue & ~ff_slot.write);
	assign wr_n		= ~(w_issue & ff_slot.write);
	assign address	= ff_slot.address;
	assign wdata	= ff_slot.data;

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_slot.valid <= 1'b0;
		end
		else if (accept) begin
			ff_slot <= vram_req;
		end
		else if (w_issue) begin
			ff_slot.valid <= 1'b0;
		end
	end

	// ------------------------------
	// Byte lane steering
	// ------------------------------
	// Shifts in step with the store's read pipeline
	always_ff @(posedge clk) begin
		ff_lane_q <= {ff_lane_q[`VDP_VRAM_LATENCY-2:0], w_issue & ~ff_slot.write & ff_slot.address[0]};
	end

	assign w_lane_hi = ff_lane_q[`VDP_VRAM_LATENCY-1];

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_byte_valid <= 1'b0;
		end
		else begin
			ff_byte_valid <= rsp.rdata_en;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp.rdata_en) begin
			ff_read_byte <= w_lane_hi ? rsp.rdata[15:8] : rsp.rdata[7:0];	// Odd byte is the high lane
		end
	end

	assign byte_valid	= ff_byte_valid;
	assign read_byte	= ff_read_byte;

endmodule

// ==== vram_store.sv ====
`timescale 1ns/1ps
`include "vdp_params.svh"

module vram_store (
	input								clk,
	input								w_n_reset,
	input								rd_n,
	input								wr_n,
	input			[`VDP_VRAM_AW-1:0]	address,
	input			[7:0]				wdata,
	output	logic						busy,
	output	vdp_vram_pkg::vram_rsp_t	rsp
);

	logic	[15:0]	mem [0:(1 << (`VDP_VRAM_AW-1))-1];	// 64K words
	logic	[$clog2(`VDP_VRAM_INIT_CYCLES)-1:0]	ff_init_cnt;
	logic							ff_init_busy;
	logic							ff_strobe_busy;		// Turnaround after each access
	logic	[`VDP_VRAM_LATENCY-1:0]	ff_en_pipe;
	logic	[15:0]					ff_word_pipe [`VDP_VRAM_LATENCY];

	// ------------------------------
	// Busy
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_init_cnt		<= '0;
			ff_init_busy	<= 1'b1;
			ff_strobe_busy	<= 1'b0;
		end
		else begin
			if (ff_init_busy) begin
				ff_init_cnt <= ff_init_cnt + 1'b1;
				if (ff_init_cnt == `VDP_VRAM_INIT_CYCLES - 1) begin
					ff_init_busy <= 1'b0;		// Init done
				end
			end
			ff_strobe_busy <= ~rd_n | ~wr_n;
		end
	end

	assign busy = ff_init_busy | ff_strobe_busy;

	// ------------------------------
	// Array and read pipeline
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_en_pipe <= '0;
		end
		else begin
			ff_en_pipe <= {ff_en_pipe[`VDP_VRAM_LATENCY-2:0], ~rd_n};
		end
	end

	always_ff @(posedge clk) begin
		if (!wr_n) begin
			if (address[0]) begin
				mem[address[`VDP_VRAM_AW-1:1]][15:8] <= wdata;	// Odd byte
			end
			else begin
				mem[address[`VDP_VRAM_AW-1:1]][7:0] <= wdata;
			end
		end
		if (!rd_n) begin
			ff_word_pipe[0] <= mem[address[`VDP_VRAM_AW-1:1]];
		end
		for (int i = 1; i < `VDP_VRAM_LATENCY; i++) begin
			ff_word_pipe[i] <= ff_word_pipe[i-1];
		end
	end

	assign rsp.rdata_en	= ff_en_pipe[`VDP_VRAM_LATENCY-1];
	assign rsp.rdata	= ff_word_pipe[`VDP_VRAM_LATENCY-1];

endmodule

// ==== vdp_cpu_port_top.sv ====
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_cpu_port_top (
	input								clk,
	input								w_n_reset,
	input	vdp_bus_pkg::vdp_host_req_t	host,
	output	logic						ack,
	output	logic	[7:0]				rdata,
	output	vdp_bus_pkg::vdp_regs_t		regs
);

	vdp_vram_pkg::vram_req_t	w_vram_req;
	vdp_vram_pkg::vram_rsp_t	w_rsp;
	logic						w_accept;
	logic						w_byte_valid;
	logic	[7:0]				w_read_byte;
	logic						w_rd_n;
	logic						w_wr_n;
	logic						w_busy;
	logic	[`VDP_VRAM_AW-1:0]	w_address;
	logic	[7:0]				w_wdata;

	// ------------------------------
	// Stage 1, host ports
	// ------------------------------
	vdp_port_decoder u_decoder (
		.clk			( clk			),
		.w_n_reset		( w_n_reset		),
		.host			( host			),
		.ack			( ack			),
		.rdata			( rdata			),
		.vram_req		( w_vram_req	),
		.accept			( w_accept		),
		.byte_valid		( w_byte_valid	),
		.read_byte		( w_read_byte	),
		.regs			( regs			)
	);

	// ------------------------------
	// Stage 2, VRAM access slot
	// ------------------------------
	vdp_vram_sequencer u_sequencer (
		.clk			( clk			),
		.w_n_reset		( w_n_reset		),
		.vram_req		( w_vram_req	),
		.accept			( w_accept		),
		.rd_n			( w_rd_n		),
		.wr_n			( w_wr_n		),
		.address		( w_address		),
		.wdata			( w_wdata		),
		.busy			( w_busy		),
		.rsp			( w_rsp			),
		.byte_valid		( w_byte_valid	),
		.read_byte		( w_read_byte	)
	);

	// Stage 3, stands in for the SDRAM controller
	vram_store u_store (
		.clk			( clk			),
		.w_n_reset		( w_n_reset		),
		.rd_n			( w_rd_n		),
		.wr_n			( w_wr_n		),
		.address		( w_address		),
		.wdata			( w_wdata		),
		.busy			( w_busy		),
		.rsp			( w_rsp			)
	);

endmodule

// ==== vdp_cpu_port_properties.sv ====
`timescale 1ns/1ps

module vdp_cpu_port_properties (
	input								clk,
	input								w_n_reset,
	input	vdp_bus_pkg::vdp_host_req_t	host,
	input								ack,
	input								rd_n,
	input								wr_n,
	input								busy
);

	// ------------------------------
	// Host side
	// ------------------------------
	ack_single_cycle: assert property (@(posedge clk) disable iff (!w_n_reset)
		ack |=> !ack)
		else $error("ack held high for two cycles");

	// Port 1 is write only
	ctrl_port_write_only: assert property (@(posedge clk) disable iff (!w_n_reset)
		(host.req && (host.port == vdp_bus_pkg::PORT_CTRL)) |-> host.wr)
		else $error("read request on control port");

	// ------------------------------
	// VRAM side
	// ------------------------------
	strobes_exclusive: assert property (@(posedge clk) disable iff (!w_n_reset)
		!(!rd_n && !wr_n))
		else $error("rd_n and wr_n low together");

	no_strobe_when_busy: assert property (@(posedge clk) disable iff (!w_n_reset)
		busy |-> (rd_n && wr_n))
		else $error("VRAM strobe while store busy");

endmodule

// Strobes and busy are internal nets of the top
bind vdp_cpu_port_top vdp_cpu_port_properties u_properties (
	.clk		( clk		),
	.w_n_reset	( w_n_reset	),
	.host		( host		),
	.ack		( ack		),
	.rd_n		( w_rd_n	),
	.wr_n		( w_wr_n	),
	.busy		( w_busy	)
);

// ==== vdp_cpu_port_tb.sv ====
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_cpu_port_tb;

	logic							clk;
	logic							w_n_reset;
	vdp_bus_pkg::vdp_host_req_t		host;
	logic							ack;
	logic	[7:0]					rdata;
	vdp_bus_pkg::vdp_regs_t			regs;

	// Reference model state
	logic	[7:0]	ref_mem [0:(1 << `VDP_VRAM_AW)-1];		// Byte shadow of VRAM
	logic	[7:0]	ref_regs [0:`VDP_REG_COUNT-1];
	logic	[13:0]	ref_addr_lo;							// Bits 16..14 from R#14
	int				cycle_count;
	int				reset_done_cycle;
	logic			read_in_flight;							// Read waiting for its ack
	logic	[7:0]	exp_read;
	string			test_name;

	vdp_cpu_port_top dut (
		.clk		( clk		),
		.w_n_reset	( w_n_reset	),
		.host		( host		),
		.ack		( ack		),
		.rdata		( rdata		),
		.regs		( regs		)
	);

	always #4 clk = ~clk;		// 8 ns period

	// ------------------------------
	// Checks and timeout
	// ------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Longest run is near 5000 cycles
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= 20000) begin
			$display("Run did not finish within %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	// Compares each data read in its ack cycle
	always @(posedge clk) begin
		if (ack && read_in_flight) begin
			read_in_flight = 1'b0;
			check_value(test_name, {24'h0, exp_read}, {24'h0, rdata});
		end
	end

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [`VDP_VRAM_AW-1:0] ref_address();
		return {ref_regs[14][2:0], ref_addr_lo};
	endfunction

	// Byte the next port 0 read must return
	function automatic logic [7:0] expected_read();
		return ref_mem[ref_address()];
	endfunction

	task automatic step_address();
		logic	[14:0]	next_lo;
		next_lo		= {1'b0, ref_addr_lo} + 15'd1;
		ref_addr_lo	= next_lo[13:0];
		if (next_lo[14]) begin
			ref_regs[14][2:0] = ref_regs[14][2:0] + 3'd1;	// Carry into the bank
		end
	endtask

	// ------------------------------
	// Host bus
	// ------------------------------
	task automatic host_access(input logic wr, input vdp_bus_pkg::vdp_port_e port,
			input logic [7:0] data, output logic [7:0] read_value);
		int		wait_cycles;
		logic	got_ack;
		wait_cycles	= 0;
		got_ack		= 1'b0;
		read_value	= 8'h00;
		@(posedge clk);
		#1;
		host.req	= 1'b1;
		host.wr		= wr;
		host.port	= port;
		host.wdata	= data;
		while (!got_ack && (wait_cycles < 200)) begin
			@(posedge clk);
			got_ack		= ack;
			read_value	= rdata;		// Valid in the ack cycle
			#1;
			host.req	= 1'b0;			// One cycle pulse
			wait_cycles++;
		end
		if (!got_ack) begin
			$display("No ack from port %0d within 200 cycles", port);
			$display("SIMULATION FAILED");
			$fatal(1, "host access timed out");
		end
	endtask

	task automatic write_port(input vdp_bus_pkg::vdp_port_e port, input logic [7:0] data);
		logic	[7:0]	unused_byte;
		host_access(1'b1, port, data, unused_byte);
	endtask

	task automatic read_port(output logic [7:0] value);
		host_access(1'b0, vdp_bus_pkg::PORT_DATA, 8'h00, value);
	endtask

	task automatic set_address(input logic [13:0] addr, input logic write_mode);
		write_port(vdp_bus_pkg::PORT_CTRL, addr[7:0]);
		write_port(vdp_bus_pkg::PORT_CTRL, {1'b0, write_mode, addr[13:8]});
		ref_addr_lo = addr;
	endtask

	task automatic write_register(input logic [5:0] num, input logic [7:0] value);
		write_port(vdp_bus_pkg::PORT_CTRL, value);
		write_port(vdp_bus_pkg::PORT_CTRL, {2'b10, num});	// Flag set
		ref_regs[num] = value;
	endtask

	task automatic write_data(input logic [7:0] data);
		write_port(vdp_bus_pkg::PORT_DATA, data);
		ref_mem[ref_address()] = data;
		step_address();
	endtask

	task automatic read_data(output logic [7:0] value);
		exp_read		= expected_read();
		read_in_flight	= 1'b1;
		read_port(value);
		step_address();
	endtask

	task automatic check_regs();
		for (int i = 0; i < `VDP_REG_COUNT; i++) begin
			check_value($sformatf("%s R#%0d", test_name, i), {24'h0, ref_regs[i]},
				{24'h0, regs[i]});
		end
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		logic	[7:0]	value;
		logic	[13:0]	start;
		logic	[5:0]	reg_num;
		int				count;
		int				pick;
		clk				= 1'b0;
		w_n_reset		= 1'b0;
		host			= '0;
		cycle_count		= 0;
		read_in_flight	= 1'b0;
		exp_read		= 8'h00;
		test_name		= "reset";
		for (int i = 0; i < `VDP_REG_COUNT; i++) begin
			ref_regs[i] = 8'h00;
		end
		void'($urandom(32'hfab4_56ae));
		repeat (5) @(posedge clk);
		#1;
		w_n_reset			= 1'b1;
		reset_done_cycle	= cycle_count;

		// Read right after reset waits out store init
		test_name = "read after init";
		set_address(14'h0000, 1'b1);
		write_data(8'ha5);
		set_address(14'h0000, 1'b0);
		read_data(value);
		check_value("read waits for init", 32'd1,
			{31'd0, (cycle_count - reset_done_cycle) >= `VDP_VRAM_INIT_CYCLES});

		test_name = "register write";
		write_register(6'd0, 8'h12);
		write_register(6'd1, 8'h40);
		write_register(6'd7, 8'hf4);
		write_register(6'd23, 8'h5a);
		write_register(6'd47, 8'h81);
		check_regs();

		// Even and odd start, both lanes
		test_name = "write then read back";
		for (int pass = 0; pass < 2; pass++) begin
			start = (pass == 0) ? 14'h0100 : 14'h0203;
			count = (pass == 0) ? 8 : 5;
			set_address(start, 1'b1);
			for (int k = 0; k < count; k++) begin
				write_data(8'($urandom()));
			end
			set_address(start, 1'b0);
			for (int k = 0; k < count; k++) begin
				read_data(value);
			end
		end

		test_name = "bank crossing";
		write_register(6'd14, 8'h01);
		set_address(14'h0000, 1'b1);
		write_data(8'h11);
		set_address(14'h3ffe, 1'b1);
		for (int k = 0; k < 4; k++) begin
			write_data(8'(8'hc0 + k));		// Last two land in bank 2
		end
		check_value("R#14 after carry", 32'h02, {24'h0, regs[14]});
		check_regs();
		set_address(14'h0000, 1'b0);
		read_data(value);					// Bank 2
		write_register(6'd14, 8'h01);
		set_address(14'h0000, 1'b0);
		read_data(value);					// Bank 1, same offset
		set_address(14'h3ffe, 1'b0);
		repeat (4) read_data(value);

		// Window 0x000..0x0ff of bank 0 is fully written first
		test_name = "random mix";
		write_register(6'd14, 8'h00);
		set_address(14'h0000, 1'b1);
		repeat (256) write_data(8'($urandom()));
		for (int op = 0; op < 300; op++) begin
			pick = $urandom_range(0, 9);
			if (pick < 2) begin
				set_address(14'($urandom_range(0, 255)), 1'($urandom()));
			end
			else if (pick == 2) begin
				reg_num = 6'($urandom_range(0, 47));
				if (reg_num == 6'd14) begin
					reg_num = 6'd15;		// Bank stays at 0
				end
				write_register(reg_num, 8'($urandom()));
			end
			else begin
				if (ref_addr_lo > 14'h00ff) begin
					set_address(14'($urandom_range(0, 255)), 1'($urandom()));
				end
				if (pick < 6) begin
					write_data(8'($urandom()));
				end
				else begin
					read_data(value);
				end
			end
			repeat ($urandom_range(0, 3)) @(posedge clk);
		end
		check_regs();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== vdp_cpu_port.f ====
+incdir+.
vdp_bus_pkg.sv
vdp_vram_pkg.sv
vdp_port_decoder.sv
vdp_vram_sequencer.sv
vram_store.sv
vdp_cpu_port_top.sv
vdp_cpu_port_properties.sv
vdp_cpu_port_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the CPU port testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	-f vdp_cpu_port.f \
	--top-module vdp_cpu_port_tb \
	-Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vvdp_cpu_port_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit "$status"
fi

exit 0
